// ==== sources.f ====
logic/alien_pkg.sv
logic/alien_motion.sv
logic/alien_window.sv
logic/alien_bitmap.sv
logic/alien_row.sv
tests/alien_row_checker.sv
tests/alien_row_asserts.sv
tests/alien_row_tb.sv

// ==== Bender.yml ====
package:
  name: alien_row

sources:
  - files:
      - logic/alien_pkg.sv
      - logic/alien_motion.sv
      - logic/alien_window.sv
      - logic/alien_bitmap.sv
      - logic/alien_row.sv
  - target: test
    files:
      - tests/alien_row_checker.sv
      - tests/alien_row_asserts.sv
      - tests/alien_row_tb.sv

// ==== tests/alien_row_tb.sv ====
// Testbench for the alien row; drives pixel probes and random pixels until the row reaches the bottom
`timescale 1ns/1ps

module alien_row_tb;

    localparam int MOVE_PERIOD = 7;
    localparam int SEED        = 80172;
    localparam int TAIL_CYCLES = 200;

    // About 800 steps to loser, 8 cycles each, then the tail and some slack
    localparam int MARCH_CYCLES   = 800 * (MOVE_PERIOD + 1);
    localparam int TIMEOUT_CYCLES = MARCH_CYCLES + TAIL_CYCLES + 3400;

    logic                             clk;
    logic                             rst_n;
    alien_pkg::coord_t                pixel_row;
    alien_pkg::coord_t                pixel_column;
    logic [alien_pkg::NUM_ALIENS-1:0] active;
    alien_pkg::pixel_t                pixel;
    logic                             loser;

    int model_row;
    int model_col;
    int check_count;
    int error_count;
    int cycle_count;

    alien_row #(
        .MOVE_PERIOD (MOVE_PERIOD)
    ) dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .pixel_row    (pixel_row),
        .pixel_column (pixel_column),
        .active       (active),
        .pixel        (pixel),
        .loser        (loser)
    );

    alien_row_checker #(
        .MOVE_PERIOD (MOVE_PERIOD)
    ) checker_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .pixel_row      (pixel_row),
        .pixel_column   (pixel_column),
        .active         (active),
        .pixel          (pixel),
        .loser          (loser),
        .dut_anchor_row (dut_i.anchor_row),
        .dut_anchor_col (dut_i.anchor_col),
        .model_row      (model_row),
        .model_col      (model_col),
        .check_count    (check_count),
        .error_count    (error_count)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic drive_pixel(int row, int col);
        @(negedge clk);
        pixel_row    = 12'(row);
        pixel_column = 12'(col);
    endtask

    // Mostly near the row, now and then anywhere on a 640x480 screen
    task automatic drive_random();
        int pick;
        pick = int'($urandom % 4);
        if (pick != 0)
            drive_pixel(model_row + int'($urandom % 20), model_col + int'($urandom % 160));
        else
            drive_pixel(int'($urandom % 480), int'($urandom % 640));
    endtask

    // Every sprite row of every alien, plus the gap to the next window
    task automatic sweep_aliens();
        for (int k = 0; k < 5; k++)
            for (int r = 0; r < 16; r++)
                for (int c = 0; c < 32; c++)
                    drive_pixel(model_row + 1 + r, model_col + 32 * k + 1 + c);
    endtask

    initial
    begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: loser did not rise within %0d cycles", TIMEOUT_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    initial
    begin
        rst_n        = 1'b0;
        pixel_row    = '0;
        pixel_column = '0;
        void'($urandom(SEED));
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Reset position 20/246, first lit pixel of alien 0 and its neighbours
        drive_pixel(21, 253);
        drive_pixel(20, 253);
        drive_pixel(37, 253);
        drive_pixel(21, 246);
        drive_pixel(21, 263);

        sweep_aliens();
        while (loser !== 1'b1)
            drive_random();
        repeat (TAIL_CYCLES) drive_random();

        @(negedge clk);
        $display("Checks: %0d  errors: %0d  assertion failures: %0d", check_count,
                 error_count, dut_i.asserts_i.failures);
        if (error_count == 0 && dut_i.asserts_i.failures == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== tests/alien_row_asserts.sv ====
// Concurrent checks on the alien row outputs, bound into every alien_row instance
`timescale 1ns/1ps

module alien_row_asserts
(
    input logic                             clk,
    input logic                             rst_n,
    input logic [alien_pkg::NUM_ALIENS-1:0] active,
    input alien_pkg::pixel_t                pixel,
    input logic                             loser
);

    int failures = 0;

    // Windows never overlap
    one_alien_a: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(active))
    else
    begin
        $error("More than one alien flag is active at once");
        failures++;
    end

    lit_needs_alien_a: assert property (@(posedge clk) disable iff (!rst_n)
        (pixel != 4'h0) |-> (active != '0))
    else
    begin
        $error("Pixel is lit while no alien flag is active");
        failures++;
    end

    // The row only moves down
    loser_holds_a: assert property (@(posedge clk) disable iff (!rst_n) !$fell(loser))
    else
    begin
        $error("Loser level fell after it had risen");
        failures++;
    end

endmodule

bind alien_row alien_row_asserts asserts_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .active (active),
    .pixel  (pixel),
    .loser  (loser)
);

// ==== tests/alien_row_checker.sv ====
// Reference model of the alien row march and sprite; compares the DUT outputs on every rising edge
`timescale 1ns/1ps

module alien_row_checker
#(
    parameter int MOVE_PERIOD = 7
)
(
    input  logic                             clk,
    input  logic                             rst_n,
    input  alien_pkg::coord_t                pixel_row,
    input  alien_pkg::coord_t                pixel_column,
    input  logic [alien_pkg::NUM_ALIENS-1:0] active,
    input  alien_pkg::pixel_t                pixel,
    input  logic                             loser,
    input  alien_pkg::coord_t                dut_anchor_row,
    input  alien_pkg::coord_t                dut_anchor_col,
    output int                               model_row,
    output int                               model_col,
    output int                               check_count,
    output int                               error_count
);

    // March rules of the row
    localparam int ALIENS    = 5;
    localparam int SIZE      = 16;
    localparam int PITCH     = 32;
    localparam int START_ROW = 20;
    localparam int START_COL = 246;
    localparam int STEP_COL  = 12;
    localparam int STEP_ROW  = 24;
    localparam int LEFT_TURN = 21;
    localparam int RIGHT_TURN = 560;
    localparam int LOSE_ROW  = 380;

    // One pattern per pair of sprite rows, bit c lights column c
    localparam logic [15:0] SPRITE_ROWS [8] = '{
        16'h03C0,
        16'h0FF0,
        16'h3FFC,
        16'hF3CF,
        16'hFFFF,
        16'h0C30,
        16'h33CC,
        16'hCC33
    };

    bit moving_left;
    int period_count;

    // Expected {loser, pixel, active} for one pixel and anchor
    function automatic logic [9:0] expect_outputs(int prow, int pcol, int arow, int acol);
        logic [4:0] exp_active;
        logic [3:0] exp_pixel;
        int         first_col;
        exp_active = '0;
        exp_pixel  = 4'h0;
        for (int k = 0; k < ALIENS; k++)
        begin
            first_col = acol + k * PITCH + 1;
            if (prow > arow && prow <= arow + SIZE && pcol >= first_col &&
                pcol < first_col + SIZE)
            begin
                exp_active[k] = 1'b1;
                if (SPRITE_ROWS[(prow - arow - 1) / 2][pcol - first_col])
                    exp_pixel = 4'hF;
            end
        end
        return {(arow > LOSE_ROW), exp_pixel, exp_active};
    endfunction

    task automatic compare_value(string name, logic [15:0] expected, logic [15:0] actual);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("Error at %0t: %s expected 0x%0h, got 0x%0h", $time, name, expected,
                     actual);
        end
    endtask

    // One march step per period, same thresholds as the hardware
    task automatic step_model();
        if (period_count != MOVE_PERIOD)
        begin
            period_count++;
            return;
        end
        period_count = 0;
        if (!moving_left)
        begin
            if (model_col > RIGHT_TURN)
            begin
                model_row   = model_row + STEP_ROW;
                moving_left = 1'b1;
            end
            else
                model_col = model_col + STEP_COL;
        end
        else
        begin
            if (model_col < LEFT_TURN)
            begin
                model_row   = model_row + STEP_ROW;
                moving_left = 1'b0;
            end
            else
                model_col = model_col - STEP_COL;
        end
    endtask

    initial
    begin
        check_count = 0;
        error_count = 0;
    end

    // Compare before the model steps, the DUT anchor moves on this same edge
    always @(posedge clk or negedge rst_n)
    begin
        logic [9:0] exp_out;
        if (!rst_n)
        begin
            model_row    = START_ROW;
            model_col    = START_COL;
            moving_left  = 1'b0;
            period_count = 0;
        end
        else
        begin
            exp_out = expect_outputs(pixel_row, pixel_column, model_row, model_col);
            compare_value("active", 16'(exp_out[4:0]), 16'(active));
            compare_value("pixel", 16'(exp_out[8:5]), 16'(pixel));
            compare_value("loser", 16'(exp_out[9]), 16'(loser));
            compare_value("anchor_row", 16'(model_row), 16'(dut_anchor_row));
            compare_value("anchor_col", 16'(model_col), 16'(dut_anchor_col));
            step_model();
        end
    end

endmodule

// ==== logic/alien_row.sv ====
// Top level of the marching alien row; maps a VGA pixel coordinate to hit flags, colour and loser
`timescale 1ns/1ps

module alien_row
#(
    parameter int MOVE_PERIOD = 16000000
)
(
    input  logic                             clk,
    input  logic                             rst_n,
    input  alien_pkg::coord_t                pixel_row,
    input  alien_pkg::coord_t                pixel_column,
    output logic [alien_pkg::NUM_ALIENS-1:0] active,
    output alien_pkg::pixel_t                pixel,
    output logic                             loser
);

    alien_pkg::coord_t  anchor_row;
    alien_pkg::coord_t  anchor_col;
    alien_pkg::offset_t local_row;
    alien_pkg::offset_t local_col;

    // Only registered part of the design
    alien_motion #(
        .MOVE_PERIOD (MOVE_PERIOD)
    ) motion_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .anchor_row (anchor_row),
        .anchor_col (anchor_col)
    );

    alien_window window_i (
        .pixel_row    (pixel_row),
        .pixel_column (pixel_column),
        .anchor_row   (anchor_row),
        .anchor_col   (anchor_col),
        .active       (active),
        .local_row    (local_row),
        .local_col    (local_col)
    );

    alien_bitmap bitmap_i (
        .active    (active),
        .local_row (local_row),
        .local_col (local_col),
        .pixel     (pixel)
    );

    // Row only ever moves down, so this level stays high once set
    assign loser = (anchor_row > alien_pkg::LOSE_ROW);

endmodule

// ==== logic/alien_bitmap.sv ====
// Shared sprite lookup; turns a local offset inside the hit alien into a pixel colour
`timescale 1ns/1ps

module alien_bitmap
(
    input  logic [alien_pkg::NUM_ALIENS-1:0] active,
    input  alien_pkg::offset_t               local_row,
    input  alien_pkg::offset_t               local_col,
    output alien_pkg::pixel_t                pixel
);

    logic                                any_active;
    logic [2:0]                          pattern_sel;
    logic [alien_pkg::SPRITE_SIZE-1:0]   pattern;
    logic                                lit;

    // Offsets are zero outside every window, so gate with the hit flags
    assign any_active = |active;

    // Pairs of rows share a pattern, the low row bit does not matter
    assign pattern_sel = local_row[3:1];
    assign pattern     = alien_pkg::ALIEN_BITMAP[pattern_sel];

    assign lit = pattern[local_col];

    assign pixel = (any_active && lit) ? alien_pkg::PIXEL_ON : alien_pkg::PIXEL_OFF;

endmodule

// ==== logic/alien_window.sv ====
// Hit test of a pixel against the five alien windows; gives the hit flags and the local sprite offset
`timescale 1ns/1ps

module alien_window
(
    input  alien_pkg::coord_t                  pixel_row,
    input  alien_pkg::coord_t                  pixel_column,
    input  alien_pkg::coord_t                  anchor_row,
    input  alien_pkg::coord_t                  anchor_col,
    output logic [alien_pkg::NUM_ALIENS-1:0]   active,
    output alien_pkg::offset_t                 local_row,
    output alien_pkg::offset_t                 local_col
);

    alien_pkg::coord_t row_diff;
    logic              row_hit;

    alien_pkg::coord_t col_first [alien_pkg::NUM_ALIENS];
    alien_pkg::coord_t col_diff  [alien_pkg::NUM_ALIENS];
    logic              col_hit   [alien_pkg::NUM_ALIENS];

    // All aliens share one band of rows, anchor_row+1 to anchor_row+16
    // The greater-than test keeps the subtraction from wrapping
    assign row_diff = pixel_row - anchor_row - 12'd1;
    assign row_hit  = (pixel_row > anchor_row) && (row_diff < alien_pkg::SPRITE_SIZE);

    // One column window per alien, spaced by the pitch
    for (genvar k = 0; k < alien_pkg::NUM_ALIENS; k++)
    begin : g_col
        assign col_first[k] = anchor_col + 12'(k * alien_pkg::ALIEN_PITCH) + 12'd1;
        assign col_diff[k]  = pixel_column - col_first[k];
        assign col_hit[k]   = (pixel_column >= col_first[k]) &&
                              (col_diff[k] < alien_pkg::SPRITE_SIZE);
    end

    // Windows never overlap, so at most one alien matches
    always_comb
    begin
        active    = '0;
        local_row = '0;
        local_col = '0;
        for (int k = 0; k < alien_pkg::NUM_ALIENS; k++)
        begin
            if (row_hit && col_hit[k])
            begin
                active[k] = 1'b1;
                local_row = row_diff[3:0];
                local_col = col_diff[k][3:0];
            end
        end
    end

endmodule

// ==== logic/alien_motion.sv ====
// March controller for the alien row; steps the top-left anchor once every MOVE_PERIOD+1 clocks
`timescale 1ns/1ps

module alien_motion
#(
    parameter int MOVE_PERIOD = 16000000
)
(
    input  logic              clk,
    input  logic              rst_n,
    output alien_pkg::coord_t anchor_row,
    output alien_pkg::coord_t anchor_col
);

    // Counter just wide enough to hold MOVE_PERIOD
    localparam int CNT_W = (MOVE_PERIOD > 0) ? $clog2(MOVE_PERIOD + 1) : 1;

    logic [CNT_W-1:0]  count;
    logic              period_done;

    alien_pkg::dir_e   dir;
    alien_pkg::dir_e   dir_next;
    alien_pkg::coord_t row_next;
    alien_pkg::coord_t col_next;

    assign period_done = (count == CNT_W'(MOVE_PERIOD));

    // Next anchor and direction for one march step
    always_comb
    begin
        row_next = anchor_row;
        col_next = anchor_col;
        dir_next = dir;
        case (dir)
            alien_pkg::DIR_RIGHT:
            begin
                if (anchor_col > alien_pkg::RIGHT_LIMIT)
                begin
                    // Hit the right edge, drop and turn
                    row_next = anchor_row + alien_pkg::STEP_ROW;
                    dir_next = alien_pkg::DIR_LEFT;
                end
                else
                begin
                    col_next = anchor_col + alien_pkg::STEP_COL;
                end
            end
            alien_pkg::DIR_LEFT:
            begin
                if (anchor_col < alien_pkg::LEFT_LIMIT)
                begin
                    row_next = anchor_row + alien_pkg::STEP_ROW;
                    dir_next = alien_pkg::DIR_RIGHT;
                end
                else
                begin
                    col_next = anchor_col - alien_pkg::STEP_COL;
                end
            end
            default:
            begin
                dir_next = alien_pkg::DIR_RIGHT;
            end
        endcase
    end

    // Period counter and anchor registers
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            count      <= '0;
            anchor_row <= alien_pkg::START_ROW;
            anchor_col <= alien_pkg::START_COL;
            dir        <= alien_pkg::DIR_RIGHT;
        end
        else if (period_done)
        begin
            count      <= '0;
            anchor_row <= row_next;
            anchor_col <= col_next;
            dir        <= dir_next;
        end
        else
        begin
            count <= count + CNT_W'(1);
        end
    end

endmodule

// ==== logic/alien_pkg.sv ====
// Shared types, geometry, march constants and sprite bitmap for the alien row, used by scoped name
package alien_pkg;

    // Screen coordinates cover a 640x480 display with room to spare
    typedef logic [11:0] coord_t;

    // Offset inside one 16x16 sprite
    typedef logic [3:0] offset_t;

    // 4-bit colour as driven onto the VGA pixel stream
    typedef logic [3:0] pixel_t;

    // March direction of the whole row
    typedef enum logic
    {
        DIR_RIGHT = 1'b0,
        DIR_LEFT  = 1'b1
    } dir_e;

    // Row geometry
    localparam int NUM_ALIENS  = 5;
    localparam int SPRITE_SIZE = 16;
    localparam int ALIEN_PITCH = 32;

    // Reset position of the top-left anchor
    localparam coord_t START_ROW = 12'd20;
    localparam coord_t START_COL = 12'd246;

    // Step sizes per motion period
    localparam coord_t STEP_COL = 12'd12;
    localparam coord_t STEP_ROW = 12'd24;

    // Turn thresholds, compared strictly against the anchor column
    localparam coord_t LEFT_LIMIT  = 12'd21;
    localparam coord_t RIGHT_LIMIT = 12'd560;

    // Anchor row past which the player has lost
    localparam coord_t LOSE_ROW = 12'd380;

    localparam pixel_t PIXEL_ON  = 4'hF;
    localparam pixel_t PIXEL_OFF = 4'h0;

    // Number of distinct sprite patterns, each one used for two local rows
    localparam int NUM_PATTERNS = SPRITE_SIZE / 2;

    // Sprite patterns, index p covers local rows 2p and 2p+1
    // Bit c of a pattern lights local column c
    localparam logic [0:NUM_PATTERNS-1][SPRITE_SIZE-1:0] ALIEN_BITMAP = '{
        16'h03C0,   // Antenna tip
        16'h0FF0,
        16'h3FFC,
        16'hF3CF,   // Eyes
        16'hFFFF,   // Full body
        16'h0C30,
        16'h33CC,
        16'hCC33    // Legs
    };

endpackage
